// File: src/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

   // Instruction field widths
   localparam int wordWidth    = 32;
   localparam int regAddrWidth = 5;
   localparam int regCount     = 32;
   localparam int opcodeWidth  = 6;
   localparam int functWidth   = 6;
   localparam int immWidth     = 16;
   localparam int jumpIdxWidth = 26;

   typedef logic [wordWidth-1:0]    wordT;
   typedef logic [regAddrWidth-1:0] regAddrT;

   // Primary opcode, bits 31:26
   typedef enum logic [opcodeWidth-1:0] {
      rType = 6'h00,
      j     = 6'h02,
      beq   = 6'h04,
      bne   = 6'h05,
      addi  = 6'h08,
      lw    = 6'h23,
      sw    = 6'h2b
   } opcodeT;

   // R-type function field, bits 5:0
   typedef enum logic [functWidth-1:0] {
      add  = 6'h20,
      sub  = 6'h22,
      andF = 6'h24,
      orF  = 6'h25,
      slt  = 6'h2a
   } functT;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluSlt
   } aluOpT;

   // Control flow kind, resolved in execute
   typedef enum logic [1:0] {
      brNone,
      brEq,
      brNe,
      brJump
   } branchKindT;

endpackage

`default_nettype wire

// File: src/pipeStagePkg.sv
`default_nettype none

package pipeStagePkg;

   // Fetch to decode
   typedef struct packed {
      mipsIsaPkg::wordT instr;
      mipsIsaPkg::wordT pcPlus4;
      logic             valid;
   } ifIdT;

   // Decoded control bits
   typedef struct packed {
      mipsIsaPkg::aluOpT      aluOp;
      logic                   aluSrcImm;
      logic                   regWrite;
      logic                   memRead;
      logic                   memWrite;
      logic                   memToReg;
      mipsIsaPkg::branchKindT branch;
   } ctrlT;

   // All control cleared, the pipeline bubble
   localparam ctrlT ctrlBubble = '{
      aluOp:     mipsIsaPkg::aluAdd,
      aluSrcImm: 1'b0,
      regWrite:  1'b0,
      memRead:   1'b0,
      memWrite:  1'b0,
      memToReg:  1'b0,
      branch:    mipsIsaPkg::brNone
   };

   // Decode to execute
   typedef struct packed {
      ctrlT                                     ctrl;
      mipsIsaPkg::wordT                         pcPlus4;
      mipsIsaPkg::wordT                         rsData;
      mipsIsaPkg::wordT                         rtData;
      mipsIsaPkg::wordT                         imm;
      logic [mipsIsaPkg::jumpIdxWidth-1:0]      jumpIndex;
      mipsIsaPkg::regAddrT                      rs;
      mipsIsaPkg::regAddrT                      rt;
      mipsIsaPkg::regAddrT                      rd;
   } idExT;

   // Execute to memory, only the controls still needed
   typedef struct packed {
      logic                regWrite;
      logic                memWrite;
      logic                memToReg;
      mipsIsaPkg::wordT    aluResult;
      mipsIsaPkg::wordT    storeData;
      mipsIsaPkg::regAddrT rd;
   } exMemT;

   // Memory to writeback
   typedef struct packed {
      logic                regWrite;
      mipsIsaPkg::regAddrT rd;
      mipsIsaPkg::wordT    data;
   } memWbT;

   // Operand source in execute
   typedef enum logic [1:0] {
      fwdNone,
      fwdMem,
      fwdWb
   } fwdSelT;

endpackage

`default_nettype wire

// File: src/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
   input  wire mipsIsaPkg::aluOpT aluOp,
   input  wire mipsIsaPkg::wordT  opA,
   input  wire mipsIsaPkg::wordT  opB,
   output mipsIsaPkg::wordT       result,
   output logic                   zero
);

   always_comb begin
      case (aluOp)
         mipsIsaPkg::aluAdd: begin
            result = opA + opB;
         end
         mipsIsaPkg::aluSub: begin
            result = opA - opB;
         end
         mipsIsaPkg::aluAnd: begin
            result = opA & opB;
         end
         mipsIsaPkg::aluOr: begin
            result = opA | opB;
         end
         // Signed compare, result is 0 or 1
         mipsIsaPkg::aluSlt: begin
            result = {31'b0, $signed(opA) < $signed(opB)};
         end
         default: begin
            result = '0;
         end
      endcase
   end

   // Equality test for beq and bne
   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: src/branchResolver.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
   input  wire mipsIsaPkg::branchKindT          kind,
   input  wire mipsIsaPkg::wordT                pcPlus4,
   input  wire mipsIsaPkg::wordT                imm,
   input  wire logic [mipsIsaPkg::jumpIdxWidth-1:0] jumpIndex,
   input  wire logic                            zero,
   output logic                                 taken,
   output mipsIsaPkg::wordT                     target
);

   mipsIsaPkg::wordT branchTarget;
   mipsIsaPkg::wordT jumpTarget;

   // PC relative, word offset
   assign branchTarget = pcPlus4 + {imm[29:0], 2'b00};
   // Region of PC plus 4 joined with the word index
   assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};

   always_comb begin
      case (kind)
         mipsIsaPkg::brEq:   taken = zero;
         mipsIsaPkg::brNe:   taken = !zero;
         mipsIsaPkg::brJump: taken = 1'b1;
         default:            taken = 1'b0;
      endcase
   end

   assign target = (kind == mipsIsaPkg::brJump) ? jumpTarget : branchTarget;

endmodule

`default_nettype wire

// File: src/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
   parameter int imemWords = 256
) (
   input  wire logic                Clk,
   input  wire logic                rst,
   input  wire logic                stall,
   input  wire logic                flush,
   input  wire logic                redirect,
   input  wire mipsIsaPkg::wordT    redirectTarget,
   input  wire logic                imemWrEn,
   input  wire logic [31:0]         imemWrAddr,
   input  wire mipsIsaPkg::wordT    imemWrData,
   output pipeStagePkg::ifIdT       ifId
);

   localparam int idxW = $clog2(imemWords);

   mipsIsaPkg::wordT pc;
   mipsIsaPkg::wordT pcPlus4;
   mipsIsaPkg::wordT imem [imemWords];

   assign pcPlus4 = pc + 32'd4;

   // PC, redirect wins, stall holds
   always_ff @(posedge Clk) begin
      if (rst) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= redirectTarget;
      end else if (!stall) begin
         pc <= pcPlus4;
      end
   end

   // Program load port, byte address, only while held in reset
   always_ff @(posedge Clk) begin
      if (rst && imemWrEn) begin
         imem[imemWrAddr[idxW+1:2]] <= imemWrData;
      end
   end

   // Fetch/decode register
   always_ff @(posedge Clk) begin
      if (rst || flush) begin
         ifId.valid <= 1'b0;
      end else if (!stall) begin
         ifId.valid <= 1'b1;
      end
      if (!stall) begin
         ifId.instr   <= imem[pc[idxW+1:2]];
         ifId.pcPlus4 <= pcPlus4;
      end
   end

endmodule

`default_nettype wire

// File: src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  wire logic                Clk,
   input  wire logic                rst,
   input  wire logic                stall,
   input  wire logic                flush,
   input  wire pipeStagePkg::ifIdT  ifId,
   input  wire pipeStagePkg::memWbT memWb,
   output pipeStagePkg::idExT       idEx
);

   mipsIsaPkg::opcodeT  opcode;
   mipsIsaPkg::functT   funct;
   pipeStagePkg::ctrlT  ctrl;
   mipsIsaPkg::regAddrT rsAddr;
   mipsIsaPkg::regAddrT rtAddr;
   mipsIsaPkg::regAddrT rdAddr;
   mipsIsaPkg::wordT    immExt;
   mipsIsaPkg::wordT    regs [mipsIsaPkg::regCount];

   assign rsAddr = ifId.instr[25:21];
   assign rtAddr = ifId.instr[20:16];
   assign rdAddr = ifId.instr[15:11];
   assign immExt = {{(32 - mipsIsaPkg::immWidth){ifId.instr[15]}},
                    ifId.instr[mipsIsaPkg::immWidth-1:0]};

   //////////////////////////////////////////////////////////////////////
   // Control decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      opcode = mipsIsaPkg::opcodeT'(ifId.instr[31:26]);
      funct  = mipsIsaPkg::functT'(ifId.instr[5:0]);
      ctrl   = pipeStagePkg::ctrlBubble;
      case (opcode)
         mipsIsaPkg::rType: begin
            ctrl.regWrite = 1'b1;
            case (funct)
               mipsIsaPkg::add:  ctrl.aluOp = mipsIsaPkg::aluAdd;
               mipsIsaPkg::sub:  ctrl.aluOp = mipsIsaPkg::aluSub;
               mipsIsaPkg::andF: ctrl.aluOp = mipsIsaPkg::aluAnd;
               mipsIsaPkg::orF:  ctrl.aluOp = mipsIsaPkg::aluOr;
               mipsIsaPkg::slt:  ctrl.aluOp = mipsIsaPkg::aluSlt;
               // Unknown function, nop included
               default:          ctrl.regWrite = 1'b0;
            endcase
         end
         mipsIsaPkg::addi: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
         end
         mipsIsaPkg::lw: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.memRead   = 1'b1;
            ctrl.memToReg  = 1'b1;
         end
         mipsIsaPkg::sw: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.memWrite  = 1'b1;
         end
         // Compare by subtraction, zero flag decides
         mipsIsaPkg::beq: begin
            ctrl.aluOp  = mipsIsaPkg::aluSub;
            ctrl.branch = mipsIsaPkg::brEq;
         end
         mipsIsaPkg::bne: begin
            ctrl.aluOp  = mipsIsaPkg::aluSub;
            ctrl.branch = mipsIsaPkg::brNe;
         end
         mipsIsaPkg::j:   ctrl.branch = mipsIsaPkg::brJump;
         default:         ctrl = pipeStagePkg::ctrlBubble;
      endcase
      // Empty slot from reset or flush
      if (!ifId.valid) begin
         ctrl = pipeStagePkg::ctrlBubble;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Register file
   //////////////////////////////////////////////////////////////////////

   // Zero register, then same-cycle writeback, then array
   function automatic mipsIsaPkg::wordT readReg(mipsIsaPkg::regAddrT addr);
      if (addr == '0) begin
         return '0;
      end
      if (memWb.regWrite && memWb.rd == addr) begin
         return memWb.data;
      end
      return regs[addr];
   endfunction

   always_ff @(posedge Clk) begin
      if (memWb.regWrite && memWb.rd != '0) begin
         regs[memWb.rd] <= memWb.data;
      end
   end

   // Decode/execute register
   always_ff @(posedge Clk) begin
      if (rst || stall || flush) begin
         idEx.ctrl <= pipeStagePkg::ctrlBubble;
      end else begin
         idEx.ctrl <= ctrl;
      end
      idEx.pcPlus4   <= ifId.pcPlus4;
      idEx.rsData    <= readReg(rsAddr);
      idEx.rtData    <= readReg(rtAddr);
      idEx.imm       <= immExt;
      idEx.jumpIndex <= ifId.instr[mipsIsaPkg::jumpIdxWidth-1:0];
      idEx.rs        <= rsAddr;
      idEx.rt        <= rtAddr;
      // R-type writes rd, immediate forms write rt
      idEx.rd        <= (opcode == mipsIsaPkg::rType) ? rdAddr : rtAddr;
   end

endmodule

`default_nettype wire

// File: src/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
   input  wire pipeStagePkg::idExT  idEx,
   input  wire pipeStagePkg::exMemT exMem,
   input  wire pipeStagePkg::memWbT memWb,
   input  wire pipeStagePkg::ifIdT  ifId,
   input  wire logic                redirect,
   output pipeStagePkg::fwdSelT     fwdA,
   output pipeStagePkg::fwdSelT     fwdB,
   output logic                     stall,
   output logic                     flush
);

   mipsIsaPkg::regAddrT ifRs;
   mipsIsaPkg::regAddrT ifRt;

   // Nearest producer first and never register 0
   function automatic pipeStagePkg::fwdSelT fwdFor(mipsIsaPkg::regAddrT src);
      if (src == '0) begin
         return pipeStagePkg::fwdNone;
      end
      if (exMem.regWrite && exMem.rd == src) begin
         return pipeStagePkg::fwdMem;
      end
      if (memWb.regWrite && memWb.rd == src) begin
         return pipeStagePkg::fwdWb;
      end
      return pipeStagePkg::fwdNone;
   endfunction

   always_comb begin
      fwdA = fwdFor(idEx.rs);
      fwdB = fwdFor(idEx.rt);
   end

   assign ifRs = ifId.instr[25:21];
   assign ifRt = ifId.instr[20:16];

   // Load in execute with its consumer in decode
   assign stall = idEx.ctrl.memRead && ifId.valid && (idEx.rd != '0) &&
                  (idEx.rd == ifRs || idEx.rd == ifRt);

   // Kill the two younger slots on a taken branch or jump
   assign flush = redirect;

endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  wire logic                 Clk,
   input  wire logic                 rst,
   input  wire pipeStagePkg::idExT   idEx,
   input  wire pipeStagePkg::fwdSelT fwdA,
   input  wire pipeStagePkg::fwdSelT fwdB,
   input  wire mipsIsaPkg::wordT     memFwdData,
   input  wire mipsIsaPkg::wordT     wbFwdData,
   output pipeStagePkg::exMemT       exMem,
   output logic                      redirect,
   output mipsIsaPkg::wordT          redirectTarget
);

   mipsIsaPkg::wordT opA;
   mipsIsaPkg::wordT regB;
   mipsIsaPkg::wordT opB;
   mipsIsaPkg::wordT aluResult;
   logic             aluZero;

   // Forwarding mux for both operands
   function automatic mipsIsaPkg::wordT pickOperand(pipeStagePkg::fwdSelT sel,
                                                    mipsIsaPkg::wordT     regVal);
      case (sel)
         pipeStagePkg::fwdMem: return memFwdData;
         pipeStagePkg::fwdWb:  return wbFwdData;
         default:              return regVal;
      endcase
   endfunction

   always_comb begin
      opA  = pickOperand(fwdA, idEx.rsData);
      regB = pickOperand(fwdB, idEx.rtData);
   end

   // Immediate forms take the sign-extended field
   assign opB  = idEx.ctrl.aluSrcImm ? idEx.imm : regB;

   aluUnit alu (
      .aluOp  (idEx.ctrl.aluOp),
      .opA    (opA),
      .opB    (opB),
      .result (aluResult),
      .zero   (aluZero)
   );

   // Runs beside the ALU on its zero flag
   branchResolver resolver (
      .kind      (idEx.ctrl.branch),
      .pcPlus4   (idEx.pcPlus4),
      .imm       (idEx.imm),
      .jumpIndex (idEx.jumpIndex),
      .zero      (aluZero),
      .taken     (redirect),
      .target    (redirectTarget)
   );

   // Execute/memory register
   always_ff @(posedge Clk) begin
      if (rst) begin
         exMem.regWrite <= 1'b0;
         exMem.memWrite <= 1'b0;
         exMem.memToReg <= 1'b0;
      end else begin
         exMem.regWrite <= idEx.ctrl.regWrite;
         exMem.memWrite <= idEx.ctrl.memWrite;
         exMem.memToReg <= idEx.ctrl.memToReg;
      end
      exMem.aluResult <= aluResult;
      // Store data comes after forwarding
      exMem.storeData <= regB;
      exMem.rd        <= idEx.rd;
   end

endmodule

`default_nettype wire

// File: src/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
   parameter int dmemWords = 256
) (
   input  wire logic                Clk,
   input  wire logic                rst,
   input  wire pipeStagePkg::exMemT exMem,
   input  wire logic [31:0]         dmemRdAddr,
   output pipeStagePkg::memWbT      memWb,
   output mipsIsaPkg::wordT         dmemRdData
);

   localparam int idxW = $clog2(dmemWords);

   mipsIsaPkg::wordT dmem [dmemWords];
   mipsIsaPkg::wordT loadData;
   mipsIsaPkg::wordT wbData;

   // Word index from the byte address
   assign loadData   = dmem[exMem.aluResult[idxW+1:2]];
   assign dmemRdData = dmem[dmemRdAddr[idxW+1:2]];

   // Loads return memory, everything else the ALU
   assign wbData = exMem.memToReg ? loadData : exMem.aluResult;

   // Data memory, cleared in reset
   always_ff @(posedge Clk) begin
      if (rst) begin
         for (int i = 0; i < dmemWords; i++) begin
            dmem[i] <= '0;
         end
      end else if (exMem.memWrite) begin
         dmem[exMem.aluResult[idxW+1:2]] <= exMem.storeData;
      end
   end

   // Memory/writeback register
   always_ff @(posedge Clk) begin
      if (rst) begin
         memWb.regWrite <= 1'b0;
      end else begin
         memWb.regWrite <= exMem.regWrite;
      end
      memWb.rd   <= exMem.rd;
      memWb.data <= wbData;
   end

endmodule

`default_nettype wire

// File: src/mipsPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline #(
   parameter int imemWords = 256,
   parameter int dmemWords = 256
) (
   input  wire logic                Clk,
   input  wire logic                rst,
   input  wire logic                imemWrEn,
   input  wire logic [31:0]         imemWrAddr,
   input  wire mipsIsaPkg::wordT    imemWrData,
   input  wire logic [31:0]         dmemRdAddr,
   output mipsIsaPkg::wordT         dmemRdData,
   output logic                     wbValid,
   output mipsIsaPkg::regAddrT      wbReg,
   output mipsIsaPkg::wordT         wbData
);

   //////////////////////////////////////////////////////////////////////
   // Stage to stage
   //////////////////////////////////////////////////////////////////////

   pipeStagePkg::ifIdT   ifId;
   pipeStagePkg::idExT   idEx;
   pipeStagePkg::exMemT  exMem;
   pipeStagePkg::memWbT  memWb;
   pipeStagePkg::fwdSelT fwdA;
   pipeStagePkg::fwdSelT fwdB;
   logic                 stall;
   logic                 flush;
   logic                 redirect;
   mipsIsaPkg::wordT     redirectTarget;

   fetchStage #(
      .imemWords (imemWords)
   ) fetch (
      .Clk            (Clk),
      .rst            (rst),
      .stall          (stall),
      .flush          (flush),
      .redirect       (redirect),
      .redirectTarget (redirectTarget),
      .imemWrEn       (imemWrEn),
      .imemWrAddr     (imemWrAddr),
      .imemWrData     (imemWrData),
      .ifId           (ifId)
   );

   // Register file writes from memWb
   decodeStage decode (
      .Clk   (Clk),
      .rst   (rst),
      .stall (stall),
      .flush (flush),
      .ifId  (ifId),
      .memWb (memWb),
      .idEx  (idEx)
   );

   hazardUnit hazard (
      .idEx     (idEx),
      .exMem    (exMem),
      .memWb    (memWb),
      .ifId     (ifId),
      .redirect (redirect),
      .fwdA     (fwdA),
      .fwdB     (fwdB),
      .stall    (stall),
      .flush    (flush)
   );

   // Forwarded values straight from the later stage registers
   executeStage execute (
      .Clk            (Clk),
      .rst            (rst),
      .idEx           (idEx),
      .fwdA           (fwdA),
      .fwdB           (fwdB),
      .memFwdData     (exMem.aluResult),
      .wbFwdData      (memWb.data),
      .exMem          (exMem),
      .redirect       (redirect),
      .redirectTarget (redirectTarget)
   );

   memoryStage #(
      .dmemWords (dmemWords)
   ) memory (
      .Clk        (Clk),
      .rst        (rst),
      .exMem      (exMem),
      .dmemRdAddr (dmemRdAddr),
      .memWb      (memWb),
      .dmemRdData (dmemRdData)
   );

   // Retirement view, register 0 never counts
   assign wbValid = memWb.regWrite && (memWb.rd != '0);
   assign wbReg   = memWb.rd;
   assign wbData  = memWb.data;

endmodule

`default_nettype wire

// File: tests/tbMipsPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsPipeline;

   localparam int imemDepth   = 64;
   localparam int dmemDepth   = 64;
   localparam int drainCycles = 16;

   logic                Clk;
   logic                rst;
   logic                imemWrEn;
   logic [31:0]         imemWrAddr;
   mipsIsaPkg::wordT    imemWrData;
   logic [31:0]         dmemRdAddr;
   mipsIsaPkg::wordT    dmemRdData;
   logic                wbValid;
   mipsIsaPkg::regAddrT wbReg;
   mipsIsaPkg::wordT    wbData;

   // Test data, one queue per column
   logic [31:0] progAddr [$];
   logic [31:0] progWord [$];
   logic [31:0] expReg [$];
   logic [31:0] expData [$];
   logic [31:0] memAddr [$];
   logic [31:0] memData [$];

   int          errorCount;
   int          wbSeen;
   int          memChecked;
   int          cycleCount;
   int          cycleLimit;
   logic        dataOk;
   logic        timedOut;
   int unsigned seedValue;
   logic [31:0] rnd;

   mipsPipeline #(
      .imemWords (imemDepth),
      .dmemWords (dmemDepth)
   ) UUT (
      .Clk        (Clk),
      .rst        (rst),
      .imemWrEn   (imemWrEn),
      .imemWrAddr (imemWrAddr),
      .imemWrData (imemWrData),
      .dmemRdAddr (dmemRdAddr),
      .dmemRdData (dmemRdData),
      .wbValid    (wbValid),
      .wbReg      (wbReg),
      .wbData     (wbData)
   );

   // 4 ns period
   always #2 Clk = ~Clk;

   //////////////////////////////////////////////////////////////////////
   // Test data and program load
   //////////////////////////////////////////////////////////////////////

   // Tag per line, then up to two hex fields
   task automatic readTestData();
      int               fd;
      int               rc;
      logic             reading;
      logic [8*8-1:0]   tag;
      logic [8*200-1:0] skipBuf;
      logic [31:0]      fieldA;
      logic [31:0]      fieldB;
      dataOk  = 1'b0;
      reading = 1'b1;
      fd = $fopen("tests/mipsTestdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test data file tests/mipsTestdata.txt");
         errorCount++;
      end else begin
         while (reading && !$feof(fd)) begin
            rc = $fscanf(fd, "%s", tag);
            if (rc != 1) begin
               reading = 1'b0;
            end else if (tag == "#") begin
               rc = $fgets(skipBuf, fd);
            end else if (tag == "E") begin
               dataOk  = 1'b1;
               reading = 1'b0;
            end else begin
               rc = $fscanf(fd, "%h %h", fieldA, fieldB);
               if (tag == "P") begin
                  progAddr.push_back(fieldA);
                  progWord.push_back(fieldB);
               end else if (tag == "W") begin
                  expReg.push_back(fieldA);
                  expData.push_back(fieldB);
               end else if (tag == "M") begin
                  memAddr.push_back(fieldA);
                  memData.push_back(fieldB);
               end else begin
                  $display("Unknown line tag in the test data file");
                  errorCount++;
                  reading = 1'b0;
               end
            end
         end
         $fclose(fd);
         if (!dataOk) begin
            $display("The test data file has no end marker or a bad line");
            errorCount++;
         end
      end
   endtask

   // Random rs and rt, rd 0, funct add
   function automatic logic [31:0] fillNop(input logic [31:0] r);
      return {6'h00, r[9:0], 5'd0, 5'd0, 6'h20};
   endfunction

   // Whole array gets filler, then the program on top
   task automatic loadProgram();
      for (int i = 0; i < imemDepth; i++) begin
         @(negedge Clk);
         rnd        = $urandom();
         imemWrEn   = 1'b1;
         imemWrAddr = i * 4;
         imemWrData = fillNop(rnd);
      end
      for (int i = 0; i < progAddr.size(); i++) begin
         @(negedge Clk);
         imemWrAddr = progAddr[i];
         imemWrData = progWord[i];
      end
      @(negedge Clk);
      imemWrEn = 1'b0;
      // Reset stays high three more cycles
      repeat (3) @(negedge Clk);
      rst = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Next retirement against the expected order
   task automatic checkWriteback();
      logic [4:0] regNow;
      if (wbSeen < expReg.size()) begin
         regNow = expReg[wbSeen][4:0];
         if (wbReg !== regNow) begin
            $display("Error: writeback %0d register, expected r%0d, actual r%0d",
                     wbSeen, regNow, wbReg);
            errorCount++;
         end
         if (wbData !== expData[wbSeen]) begin
            $display("Error: writeback %0d data, expected %h, actual %h",
                     wbSeen, expData[wbSeen], wbData);
            errorCount++;
         end
      end else begin
         $display("Unexpected extra writeback to r%0d with data %h", wbReg, wbData);
         errorCount++;
      end
      wbSeen++;
   endtask

   // Outputs sampled on the falling edge, away from register updates
   task automatic runProgram();
      cycleLimit = 8 * progAddr.size() + 50;
      while (wbSeen < expReg.size() && !timedOut) begin
         @(negedge Clk);
         cycleCount++;
         if (wbValid) begin
            checkWriteback();
         end
         if (wbSeen < expReg.size() && cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with %0d of %0d writebacks seen",
                     cycleCount, wbSeen, expReg.size());
            errorCount++;
            timedOut = 1'b1;
         end
      end
      // Halt loop must stay quiet, stores settle meanwhile
      if (!timedOut) begin
         repeat (drainCycles) begin
            @(negedge Clk);
            if (wbValid) begin
               checkWriteback();
            end
         end
      end
   endtask

   // Address on one falling edge, data compared on the next
   task automatic checkMemWord(input logic [31:0] addr, input logic [31:0] expVal);
      @(negedge Clk);
      dmemRdAddr = addr;
      @(negedge Clk);
      if (dmemRdData !== expVal) begin
         $display("Error: memory word %h, expected %h, actual %h", addr, expVal, dmemRdData);
         errorCount++;
      end
      memChecked++;
   endtask

   initial begin
      Clk        = 1'b0;
      rst        = 1'b1;
      imemWrEn   = 1'b0;
      imemWrAddr = '0;
      imemWrData = '0;
      dmemRdAddr = '0;
      errorCount = 0;
      wbSeen     = 0;
      memChecked = 0;
      cycleCount = 0;
      timedOut   = 1'b0;
      seedValue  = 32'hcd8e03cc;
      rnd        = $urandom(seedValue);
      readTestData();
      if (dataOk) begin
         loadProgram();
         runProgram();
         if (!timedOut) begin
            for (int i = 0; i < memAddr.size(); i++) begin
               checkMemWord(memAddr[i], memData[i]);
            end
         end
      end
      $display("Summary: %0d of %0d writebacks seen, %0d memory words checked, %0d errors",
               wbSeen, expReg.size(), memChecked, errorCount);
      if (errorCount == 0 && dataOk) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/mipsTestdata.txt
# P byteAddress instructionWord, W register value, M byteAddress value, all hex
# W lines list the retirements in program order, E ends the data
# ALU group, r1 = 0xf0, r2 = -3, forwarding from memory and writeback distance
P 00000000 200100f0
P 00000004 2002fffd
P 00000008 00221820
P 0000000c 00222022
P 00000010 00642824
P 00000014 00643025
P 00000018 0041382a
P 0000001c 0022402a
# Store, load back, dependent add with one stall
P 00000020 20090040
P 00000024 ad260000
P 00000028 8d2a0000
P 0000002c 01435820
P 00000030 ad2b0004
# Taken beq over two addi r12, not-taken beq, taken bne over two addi r14
P 00000034 10210002
P 00000038 200c0111
P 0000003c 200c0222
P 00000040 10220001
P 00000044 200d0033
P 00000048 15a00002
P 0000004c 200e0444
P 00000050 200e0555
# Jump over three addi r15, final store, halt on jump to self
P 00000054 08000019
P 00000058 200f0666
P 0000005c 200f0777
P 00000060 200f0888
P 00000064 200f0099
P 00000068 ad2f0008
P 0000006c 0800001b
W 01 000000f0
W 02 fffffffd
W 03 000000ed
W 04 000000f3
W 05 000000e1
W 06 000000ff
W 07 00000001
W 08 00000000
W 09 00000040
W 0a 000000ff
W 0b 000001ec
W 0d 00000033
W 0f 00000099
M 00000040 000000ff
M 00000044 000001ec
M 00000048 00000099
M 0000004c 00000000
E

// File: mipsPipeline.f
src/mipsIsaPkg.sv
src/pipeStagePkg.sv
src/aluUnit.sv
src/branchResolver.sv
src/fetchStage.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/memoryStage.sv
src/mipsPipeline.sv
tests/tbMipsPipeline.sv
